//--- Bender.yml
package:
  name: memory_upload

sources:
  - include_dirs:
      - src
    files:
      - src/msx_upload_pkg.sv
      - src/record_table.sv
      - src/upload_controller.sv
      - src/ram_filler.sv
      - src/layout_writer.sv
      - src/memory_upload.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/memory_upload_asserts.sv
      - sim/memory_upload_tb.sv

//--- filelist.f
+incdir+src
src/msx_upload_pkg.sv
src/record_table.sv
src/upload_controller.sv
src/ram_filler.sv
src/layout_writer.sv
src/memory_upload.sv
sim/memory_upload_asserts.sv
sim/memory_upload_tb.sv

//--- sim/memory_upload_asserts.sv
`timescale 1ns/1ps
`include "msx_upload_defs.svh"

module memory_upload_asserts
   import msx_upload_pkg::*;
(
   input                      clk,
   input                      reset,
   input                      ioctl_download,
   input       [15:0]         ioctl_index,
   input                      reload,
   input                      reset_rq,
   input       [`DDR3_AW-1:0] ddr3_addr,
   input                      ddr3_rd,
   input                      ddr3_ready,
   input                      ddr3_request,
   input       [`RAM_AW-1:0]  ram_addr,
   input                      ram_ce,
   input                      sdram_ready,
   input                      fill_start
);
   int                 fail_count = 0;
   logic               in_record;
   logic [`RAM_AW-1:0] last_addr;

   always @(posedge clk) begin
      if (reset || fill_start) begin
         in_record <= 1'b0;  // New block starts fresh
      end else if (ram_ce) begin
         in_record <= 1'b1;
         last_addr <= ram_addr;
      end
   end

   rd_hold: assert property (@(posedge clk) disable iff (reset)
      ddr3_rd && !ddr3_ready |=> ddr3_rd && $stable(ddr3_addr))
      else begin $error("ddr3_rd or ddr3_addr changed before ddr3_ready"); fail_count++; end

   ce_ready: assert property (@(posedge clk) disable iff (reset) ram_ce |-> sdram_ready)
      else begin $error("ram_ce without sdram_ready"); fail_count++; end

   ce_pulse: assert property (@(posedge clk) disable iff (reset) ram_ce |=> !ram_ce)
      else begin $error("ram_ce longer than one cycle"); fail_count++; end

   addr_step: assert property (@(posedge clk) disable iff (reset)
      ram_ce && in_record |-> ram_addr == last_addr + 1'b1)
      else begin $error("ram_addr did not step by one"); fail_count++; end

   idle_quiet: assert property (@(posedge clk) disable iff (reset)
      !reset_rq |-> !ddr3_rd && !ddr3_request && !ram_ce)
      else begin $error("Memory activity while idle"); fail_count++; end

   load_start: assert property (@(posedge clk) disable iff (reset)
      ($fell(ioctl_download) && ioctl_index[5:0] == 6'(`CONFIG_INDEX)) || reload |=> reset_rq)
      else begin $error("reset_rq missing after download end or reload"); fail_count++; end

endmodule

bind memory_upload memory_upload_asserts asserts_i (
   .clk            (clk),
   .reset          (reset),
   .ioctl_download (ioctl_download),
   .ioctl_index    (ioctl_index),
   .reload         (reload),
   .reset_rq       (reset_rq),
   .ddr3_addr      (ddr3_addr),
   .ddr3_rd        (ddr3_rd),
   .ddr3_ready     (ddr3_ready),
   .ddr3_request   (ddr3_request),
   .ram_addr       (ram_addr),
   .ram_ce         (ram_ce),
   .sdram_ready    (sdram_ready),
   .fill_start     (fill_start)
);

//--- sim/memory_upload_tb.sv
`timescale 1ns/1ps
`include "msx_upload_defs.svh"

module memory_upload_tb
   import msx_upload_pkg::*;
();
   localparam int UNIT_BYTES   = 1 << `FILL_UNIT_SHIFT;
   localparam int IMAGE_MAX    = 32768;
   localparam int SHADOW_BYTES = 65536;
   // Two passes of one streamed unit and two pattern units
   localparam int MAX_CYCLES   = 2 * (UNIT_BYTES * 6 + 2 * UNIT_BYTES * 3);

   logic                clk = 1'b0;
   logic                reset;
   logic                ioctl_download;
   logic [15:0]         ioctl_index;
   logic [`RAM_AW-1:0]  ioctl_addr;
   logic                reload;
   logic [7:0]          ddr3_dout;
   logic                ddr3_ready;
   logic                sdram_ready;
   logic                reset_rq;
   logic [`DDR3_AW-1:0] ddr3_addr;
   logic                ddr3_rd;
   logic                ddr3_request;
   logic [`RAM_AW-1:0]  ram_addr;
   logic [7:0]          ram_din;
   logic                ram_ce;
   block_t              slot_layout [`SLOT_BLOCKS];
   lookup_ram_t         lookup_ram [`LOOKUP_ENTRIES];

   integer              seed = 32'h73e4;
   int                  cycles = 0;
   int                  errors = 0;
   int                  ram_writes = 0;
   int                  img_len;
   int                  exp_alloc;
   int                  exp_ref;
   logic [7:0]          image [IMAGE_MAX];
   logic [7:0]          shadow [SHADOW_BYTES];
   block_t              exp_layout [`SLOT_BLOCKS];
   lookup_ram_t         exp_lookup [`LOOKUP_ENTRIES];
   int                  blk_base [$];
   int                  blk_len [$];
   int                  blk_src [$];
   int                  blk_pattern [$];  // -1 for streamed blocks
   logic                rd_accepted = 1'b0;
   logic [`DDR3_AW-1:0] rd_addr;
   string               test_name;

   always #2 clk = ~clk;

   memory_upload memory_upload_i (
      .clk            (clk),
      .reset          (reset),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_addr     (ioctl_addr),
      .reload         (reload),
      .ddr3_dout      (ddr3_dout),
      .ddr3_ready     (ddr3_ready),
      .sdram_ready    (sdram_ready),
      .reset_rq       (reset_rq),
      .ddr3_addr      (ddr3_addr),
      .ddr3_rd        (ddr3_rd),
      .ddr3_request   (ddr3_request),
      .ram_addr       (ram_addr),
      .ram_din        (ram_din),
      .ram_ce         (ram_ce),
      .slot_layout    (slot_layout),
      .lookup_ram     (lookup_ram)
   );

   // DDR3 and SDRAM models sampled on the rising edge
   always @(posedge clk) begin
      cycles      <= cycles + 1;
      rd_accepted <= ddr3_rd && ddr3_ready;
      rd_addr     <= ddr3_addr;
      if (ram_ce) begin
         ram_writes <= ram_writes + 1;
         if (ram_addr < SHADOW_BYTES) begin
            shadow[ram_addr] <= ram_din;
         end else begin
            errors++;
            $display("SDRAM write to address %0h lies outside the modelled memory", ram_addr);
         end
      end
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the upload did not finish within %0d cycles", MAX_CYCLES);
         $display("Errors: %0d data, %0d assertion", errors,
                  memory_upload_i.asserts_i.fail_count);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   always @(negedge clk) begin
      if (rd_accepted) ddr3_dout <= (rd_addr < IMAGE_MAX) ? image[rd_addr] : 8'h00;
      ddr3_ready  <= !reset && ($random(seed) & 7) != 0;  // Stall about one in eight
      sdram_ready <= !reset && ($random(seed) & 7) != 0;
   end

   function automatic logic [7:0] stream_byte(input int a);
      return 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 16) ^ 8'h5A;
   endfunction

   function automatic logic [7:0] expected_fill(input int pattern, input int offset);
      logic [8:0] o;
      o = 9'(offset);
      case (pattern)
         2:       return 8'h00;
         3:       return (o[8] == o[1]) ? 8'hFF : 8'h00;
         4:       return (o[8] != o[0]) ? 8'hFF : 8'h00;
         5:       return o[7] ? 8'hFF : 8'h00;
         default: return 8'hFF;
      endcase
   endfunction

   task automatic report_mismatch(input string what, input logic [63:0] exp,
                                  input logic [63:0] act);
      errors++;
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
   endtask

   task automatic apply_layout(input logic [3:0] slot, input logic [7:0] mode,
                               input logic [7:0] param, input mapper_t map,
                               input device_t dev, input logic [3:0] ref_ram);
      logic [1:0] m;
      logic [1:0] p;
      block_t     src;
      for (int b = 0; b < 4; b++) begin
         m   = mode[2*b +: 2];
         p   = param[2*b +: 2];
         src = exp_layout[slot*4 + p];
         case (m)
            2'd1: exp_layout[slot*4 + b] = '{src.mapper, DEVICE_NONE, src.ref_ram,
                                             src.offset_ram};
            2'd2: exp_layout[slot*4 + b] = '{map, dev, ref_ram, p};
            2'd3: exp_layout[slot*4 + b] = '{MAPPER_UNUSED, dev, ref_ram, p};
            default: ;
         endcase
      end
   endtask

   // Writes one header, its payload if streamed, and the expected results
   task automatic add_record(input logic [23:0] magic, input config_typ_t typ,
                             input logic [3:0] slot, input data_id_t id, input int units,
                             input device_t dev, input mapper_t map, input logic [7:0] mode,
                             input logic [7:0] param, input logic [2:0] pattern);
      logic [7:0] hdr [16];
      logic       stream;
      int         bytes;
      hdr     = '{default: 8'h00};
      hdr[0]  = magic[23:16];
      hdr[1]  = magic[15:8];
      hdr[2]  = magic[7:0];
      hdr[3]  = {typ, slot};
      hdr[4]  = id;
      hdr[5]  = {5'b0, units[10:8]};
      hdr[6]  = units[7:0];
      hdr[7]  = dev;
      hdr[8]  = map;
      hdr[9]  = mode;
      hdr[10] = param;
      hdr[11] = {5'b0, pattern};
      for (int i = 0; i < 16; i++) image[img_len + i] = hdr[i];
      img_len += 16;
      if (magic != `MSX_MAGIC || typ != CONFIG_SLOT_INTERNAL) return;
      stream = id != ROM_RAM && id != ROM_NONE;
      bytes  = units * UNIT_BYTES;
      if (units != 0) begin
         exp_lookup[exp_ref] = '{addr: `RAM_AW'(exp_alloc), size: 16'(units), ro: stream};
         blk_base.push_back(exp_alloc);
         blk_len.push_back(bytes);
         blk_src.push_back(img_len);
         blk_pattern.push_back(stream ? -1 : int'(pattern));
         if (stream) begin
            for (int i = 0; i < bytes; i++) image[img_len + i] = stream_byte(img_len + i);
            img_len += bytes;
         end
         exp_alloc += bytes;
      end
      apply_layout(slot, mode, param, map, dev, id == ROM_NONE ? 4'd0 : 4'(exp_ref));
      if (units != 0) exp_ref++;
   endtask

   task automatic build_image();
      for (int i = 0; i < IMAGE_MAX; i++) image[i] = 8'h00;
      exp_layout = '{default: '0};
      exp_lookup = '{default: '0};
      img_len    = 0;
      exp_alloc  = 0;
      exp_ref    = 0;
      add_record(`MSX_MAGIC, CONFIG_SLOT_INTERNAL, 4'h0, ROM_ROM, 1, DEVICE_NONE,
                 MAPPER_NONE, 8'h0A, 8'h00, 3'd0);
      add_record(`MSX_MAGIC, CONFIG_SLOT_INTERNAL, 4'h4, ROM_RAM, 1, DEVICE_FDC,
                 MAPPER_NONE, 8'h36, 8'h10, 3'd3);  // Page 1 copies page 0
      add_record(`MSX_MAGIC, CONFIG_SLOT_INTERNAL, 4'hB, ROM_RAM, 1, DEVICE_NONE,
                 MAPPER_KONAMI, 8'h82, 8'h00, 3'd5);
      add_record(`MSX_MAGIC, CONFIG_CONFIG, 4'h0, ROM_ROM, 1, DEVICE_NONE,
                 MAPPER_NONE, 8'hFF, 8'h00, 3'd1);  // Skipped type
      add_record(24'h4D5359, CONFIG_SLOT_INTERNAL, 4'h8, ROM_RAM, 1, DEVICE_NONE,
                 MAPPER_NONE, 8'hFF, 8'h00, 3'd1);  // Bad magic ends the image
   endtask

   task automatic wait_upload();
      while (!reset_rq) @(negedge clk);
      while (reset_rq) @(negedge clk);
   endtask

   task automatic check_tables_cleared();
      for (int i = 0; i < `LOOKUP_ENTRIES; i++) begin
         assert (lookup_ram[i] === '0)
            else report_mismatch($sformatf("cleared lookup[%0d]", i), '0, lookup_ram[i]);
      end
      for (int i = 0; i < `SLOT_BLOCKS; i++) begin
         assert (slot_layout[i] === '0)
            else report_mismatch($sformatf("cleared layout[%0d]", i), '0, slot_layout[i]);
      end
   endtask

   task automatic check_results();
      int         total;
      logic [7:0] exp;
      total = 0;
      for (int i = 0; i < `LOOKUP_ENTRIES; i++) begin
         assert (lookup_ram[i] === exp_lookup[i])
            else report_mismatch($sformatf("lookup[%0d]", i), exp_lookup[i], lookup_ram[i]);
      end
      for (int i = 0; i < `SLOT_BLOCKS; i++) begin
         assert (slot_layout[i] === exp_layout[i])
            else report_mismatch($sformatf("layout[%0d]", i), exp_layout[i], slot_layout[i]);
      end
      foreach (blk_base[k]) begin
         total += blk_len[k];
         for (int j = 0; j < blk_len[k]; j++) begin
            exp = blk_pattern[k] < 0 ? image[blk_src[k] + j] : expected_fill(blk_pattern[k], j);
            assert (shadow[blk_base[k] + j] === exp)
               else report_mismatch($sformatf("SDRAM[%0h]", blk_base[k] + j), exp,
                                    shadow[blk_base[k] + j]);
         end
      end
      assert (ram_writes == total) else report_mismatch("SDRAM writes", total, ram_writes);
   endtask

   initial begin
      reset          = 1'b1;
      ioctl_download = 1'b0;
      ioctl_index    = 16'h0000;
      ioctl_addr     = '0;
      reload         = 1'b0;
      ddr3_dout      = 8'h00;
      ddr3_ready     = 1'b0;
      sdram_ready    = 1'b0;
      build_image();
      repeat (3) @(negedge clk);
      reset = 1'b0;
      repeat (5) @(negedge clk);

      test_name      = "initial load";
      ioctl_index    = 16'(`CONFIG_INDEX);
      ioctl_addr     = `RAM_AW'(img_len);
      ioctl_download = 1'b1;
      repeat (8) @(negedge clk);
      ioctl_download = 1'b0;
      wait_upload();
      repeat (4) @(negedge clk);
      check_results();

      test_name = "reload";
      for (int i = 0; i < SHADOW_BYTES; i++) shadow[i] = 'x;
      ram_writes = 0;
      reload     = 1'b1;
      @(negedge clk);
      reload = 1'b0;
      repeat (4) @(negedge clk);  // Tables cleared before the first header is read
      check_tables_cleared();
      wait_upload();
      repeat (4) @(negedge clk);
      check_results();

      $display("Errors: %0d data, %0d assertion", errors, memory_upload_i.asserts_i.fail_count);
      if (errors == 0 && memory_upload_i.asserts_i.fail_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- src/layout_writer.sv
`timescale 1ns/1ps
`include "msx_upload_defs.svh"

module layout_writer
   import msx_upload_pkg::*;
(
   input                       clk,
   input                       reset,
   input                       store_start,
   input        [3:0]          store_slot,
   input        [7:0]          store_mode,
   input        [7:0]          store_param,
   input  mapper_t             store_mapper,
   input  device_t             store_device,
   input        [3:0]          store_ref,
   input  block_t              layout [`SLOT_BLOCKS],
   output logic                store_done,
   output logic                layout_wr,
   output logic [`SLOT_AW-1:0] layout_addr,
   output block_t              layout_data
);
   logic       busy;
   logic [1:0] page;
   logic [3:0] slot_q;
   logic [7:0] mode_q;
   logic [7:0] param_q;
   mapper_t    mapper_q;
   device_t    device_q;
   logic [3:0] ref_q;
   logic [1:0] m;
   logic [1:0] p;
   block_t     src;

   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= 1'b0;
         page <= 2'd0;
      end else if (store_start) begin
         busy <= 1'b1;
         page <= 2'd0;
      end else if (busy) begin
         page <= page + 1'b1;
         if (page == 2'd3) busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (store_start) begin
         slot_q   <= store_slot;
         mode_q   <= store_mode;
         param_q  <= store_param;
         mapper_q <= store_mapper;
         device_q <= store_device;
         ref_q    <= store_ref;
      end
   end

   assign m   = mode_q[2*page +: 2];
   assign p   = param_q[2*page +: 2];
   assign src = layout[{slot_q, p}];  // Sees pages already written for this record

   assign layout_addr = {slot_q, page};
   assign layout_wr   = busy && m != 2'd0;
   assign store_done  = busy && page == 2'd3;

   always_comb begin
      case (m)
         2'd1:    layout_data = '{src.mapper, DEVICE_NONE, src.ref_ram, src.offset_ram};
         2'd2:    layout_data = '{mapper_q, device_q, ref_q, p};
         default: layout_data = '{MAPPER_UNUSED, device_q, ref_q, p};
      endcase
   end

endmodule

//--- src/memory_upload.sv
`timescale 1ns/1ps
`include "msx_upload_defs.svh"

module memory_upload
   import msx_upload_pkg::*;
(
   input                        clk,
   input                        reset,
   input                        ioctl_download,
   input         [15:0]         ioctl_index,
   input         [`RAM_AW-1:0]  ioctl_addr,
   input                        reload,
   input         [7:0]          ddr3_dout,
   input                        ddr3_ready,
   input                        sdram_ready,
   output logic                 reset_rq,
   output logic  [`DDR3_AW-1:0] ddr3_addr,
   output logic                 ddr3_rd,
   output logic                 ddr3_request,
   output logic  [`RAM_AW-1:0]  ram_addr,
   output logic  [7:0]          ram_din,
   output logic                 ram_ce,
   output block_t               slot_layout [`SLOT_BLOCKS],
   output lookup_ram_t          lookup_ram [`LOOKUP_ENTRIES]
);
   logic                     fetch_req;
   logic                     fetch_ack;
   logic                     fill_start;
   logic [`RAM_AW-1:0]       fill_base;
   logic [`FILL_UNITS_W-1:0] fill_units;
   fill_pattern_t            fill_pattern;
   logic                     fill_stream;
   logic                     fill_done;
   logic                     table_clear;
   logic                     lookup_wr;
   logic [`LOOKUP_AW-1:0]    lookup_addr;
   lookup_ram_t              lookup_data;
   logic                     store_start;
   logic [3:0]               store_slot;
   logic [7:0]               store_mode;
   logic [7:0]               store_param;
   mapper_t                  store_mapper;
   device_t                  store_device;
   logic [3:0]               store_ref;
   logic                     store_done;
   logic                     layout_wr;
   logic [`SLOT_AW-1:0]      layout_addr;
   block_t                   layout_data;

   upload_controller upload_controller_i (.*);

   ram_filler ram_filler_i (.*);

   layout_writer layout_writer_i (
      .layout (slot_layout),
      .*
   );

   record_table #(.entry_t(block_t), .DEPTH(`SLOT_BLOCKS)) layout_table (
      .clk     (clk),
      .reset   (reset),
      .clear   (table_clear),
      .wr_en   (layout_wr),
      .wr_addr (layout_addr),
      .wr_data (layout_data),
      .entries (slot_layout)
   );

   record_table #(.entry_t(lookup_ram_t), .DEPTH(`LOOKUP_ENTRIES)) lookup_table (
      .clk     (clk),
      .reset   (reset),
      .clear   (table_clear),
      .wr_en   (lookup_wr),
      .wr_addr (lookup_addr),
      .wr_data (lookup_data),
      .entries (lookup_ram)
   );

endmodule

//--- src/msx_upload_defs.svh
`ifndef MSX_UPLOAD_DEFS_SVH
`define MSX_UPLOAD_DEFS_SVH

// Configuration record header
`define CONF_HEADER_BYTES 16
`define MSX_MAGIC         24'h4D5358

// Memory ports
`define DDR3_AW           28
`define RAM_AW            27

// Slot layout, 4 slots x 4 subslots x 4 pages
`define SLOT_BLOCKS       64
`define SLOT_AW           6

// RAM lookup table
`define LOOKUP_ENTRIES    16
`define LOOKUP_AW         4

// Block sizes count 16 KB units
`define FILL_UNITS_W      11
`define FILL_UNIT_SHIFT   14

`define CONFIG_INDEX      1

`endif

//--- src/msx_upload_pkg.sv
`include "msx_upload_defs.svh"

package msx_upload_pkg;

   typedef enum logic [7:0] {
      MAPPER_UNUSED = 8'd0,
      MAPPER_NONE,
      MAPPER_ASCII8,
      MAPPER_ASCII16,
      MAPPER_KONAMI,
      MAPPER_KONAMI_SCC
   } mapper_t;

   typedef enum logic [7:0] {
      DEVICE_NONE = 8'd0,
      DEVICE_FDC,
      DEVICE_ZEMINA90,
      DEVICE_MFRSD0
   } device_t;

   typedef enum logic [7:0] {
      ROM_NONE = 8'd0,
      ROM_ROM,
      ROM_RAM,
      ROM_FDC,
      ROM_FMPAC,
      ROM_GM2
   } data_id_t;

   typedef enum logic [3:0] {
      CONFIG_NONE = 4'd0,
      CONFIG_SLOT_A,
      CONFIG_SLOT_B,
      CONFIG_SLOT_INTERNAL,
      CONFIG_KBD_LAYOUT,
      CONFIG_CONFIG
   } config_typ_t;

   typedef enum logic [2:0] {
      FILL_STREAM  = 3'd0,
      FILL_ONES    = 3'd1,
      FILL_ZEROS   = 3'd2,
      FILL_CHECK_A = 3'd3,
      FILL_CHECK_B = 3'd4,
      FILL_HALF    = 3'd5
   } fill_pattern_t;

   typedef struct packed {
      mapper_t    mapper;
      device_t    device;
      logic [3:0] ref_ram;     // Index into the lookup table
      logic [1:0] offset_ram;  // 16 KB page within the block
   } block_t;

   typedef struct packed {
      logic [`RAM_AW-1:0] addr;
      logic [15:0]        size;  // In 16 KB units
      logic               ro;
   } lookup_ram_t;

endpackage

//--- src/ram_filler.sv
`timescale 1ns/1ps
`include "msx_upload_defs.svh"

module ram_filler
   import msx_upload_pkg::*;
(
   input                            clk,
   input                            reset,
   input                            fill_start,
   input        [`RAM_AW-1:0]       fill_base,
   input        [`FILL_UNITS_W-1:0] fill_units,
   input  fill_pattern_t            fill_pattern,
   input                            fill_stream,
   input                            fetch_ack,
   input        [7:0]               ddr3_dout,
   input                            sdram_ready,
   output logic                     fetch_req,
   output logic                     fill_done,
   output logic [`RAM_AW-1:0]       ram_addr,
   output logic [7:0]               ram_din,
   output logic                     ram_ce
);
   localparam int COUNT_W = `FILL_UNITS_W + `FILL_UNIT_SHIFT;

   typedef enum logic [1:0] {F_IDLE, F_FETCH, F_WRITE, F_GAP} fill_state_t;

   fill_state_t        state;
   logic [COUNT_W-1:0] remaining;
   logic [8:0]         offset;
   fill_pattern_t      pattern_q;
   logic               stream_q;
   logic [7:0]         pattern_byte;

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= F_IDLE;
         fetch_req <= 1'b0;
         fill_done <= 1'b0;
      end else begin
         fetch_req <= 1'b0;
         fill_done <= 1'b0;
         case (state)
            F_IDLE: begin
               if (fill_start) begin
                  state     <= fill_stream ? F_FETCH : F_WRITE;
                  fetch_req <= fill_stream;
               end
            end
            F_FETCH: if (fetch_ack) state <= F_WRITE;
            F_WRITE: begin
               if (sdram_ready) begin
                  if (remaining == COUNT_W'(1)) begin
                     fill_done <= 1'b1;
                     state     <= F_IDLE;
                  end else if (stream_q) begin
                     fetch_req <= 1'b1;
                     state     <= F_FETCH;
                  end else begin
                     state <= F_GAP;  // Keeps each ram_ce to one cycle
                  end
               end
            end
            default: state <= F_WRITE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == F_IDLE && fill_start) begin
         ram_addr  <= fill_base;
         remaining <= {fill_units, {`FILL_UNIT_SHIFT{1'b0}}};
         offset    <= '0;
         pattern_q <= fill_pattern;
         stream_q  <= fill_stream;
      end else if (ram_ce) begin
         ram_addr  <= ram_addr + 1'b1;
         remaining <= remaining - 1'b1;
         offset    <= offset + 1'b1;
      end
   end

   always_comb begin
      case (pattern_q)
         FILL_ZEROS:   pattern_byte = 8'h00;
         FILL_CHECK_A: pattern_byte = (offset[8] == offset[1]) ? 8'hFF : 8'h00;
         FILL_CHECK_B: pattern_byte = (offset[8] != offset[0]) ? 8'hFF : 8'h00;
         FILL_HALF:    pattern_byte = offset[7] ? 8'hFF : 8'h00;
         default:      pattern_byte = 8'hFF;  // Also codes 6 and 7
      endcase
   end

   assign ram_ce  = state == F_WRITE && sdram_ready;
   assign ram_din = stream_q ? ddr3_dout : pattern_byte;  // DDR3 byte holds until next fetch

endmodule

//--- src/record_table.sv
`timescale 1ns/1ps

module record_table
   import msx_upload_pkg::*;
#(
   parameter type entry_t = block_t,
   parameter int  DEPTH   = 16
) (
   input                            clk,
   input                            reset,
   input                            clear,
   input                            wr_en,
   input        [$clog2(DEPTH)-1:0] wr_addr,
   input  entry_t                   wr_data,
   output entry_t                   entries [DEPTH]
);

   // All-zero entry reads as unused
   always_ff @(posedge clk) begin
      if (reset || clear) begin
         for (int i = 0; i < DEPTH; i++) begin
            entries[i] <= '0;
         end
      end else if (wr_en) begin
         entries[wr_addr] <= wr_data;
      end
   end

endmodule

//--- src/upload_controller.sv
`timescale 1ns/1ps
`include "msx_upload_defs.svh"

module upload_controller
   import msx_upload_pkg::*;
(
   input                            clk,
   input                            reset,
   input                            ioctl_download,
   input        [15:0]              ioctl_index,
   input        [`RAM_AW-1:0]       ioctl_addr,
   input                            reload,
   input        [7:0]               ddr3_dout,
   input                            ddr3_ready,
   input                            fetch_req,
   input                            fill_done,
   input                            store_done,
   output logic                     reset_rq,
   output logic [`DDR3_AW-1:0]      ddr3_addr,
   output logic                     ddr3_rd,
   output logic                     ddr3_request,
   output logic                     fetch_ack,
   output logic                     fill_start,
   output logic [`RAM_AW-1:0]       fill_base,
   output logic [`FILL_UNITS_W-1:0] fill_units,
   output fill_pattern_t            fill_pattern,
   output logic                     fill_stream,
   output logic                     table_clear,
   output logic                     lookup_wr,
   output logic [`LOOKUP_AW-1:0]    lookup_addr,
   output lookup_ram_t              lookup_data,
   output logic                     store_start,
   output logic [3:0]               store_slot,
   output logic [7:0]               store_mode,
   output logic [7:0]               store_param,
   output mapper_t                  store_mapper,
   output device_t                  store_device,
   output logic [3:0]               store_ref
);
   typedef enum logic [2:0] {
      S_IDLE, S_CLEAR, S_HDR_START, S_HDR_READ, S_CHECK, S_FILL, S_STORE
   } state_t;

   state_t                state;
   logic                  download_q;
   logic                  download_end;
   logic                  load;
   logic [`RAM_AW-1:0]    image_size;
   logic [7:0]            conf [`CONF_HEADER_BYTES];
   logic [3:0]            hdr_idx;
   logic                  rd_valid;
   logic [`RAM_AW-1:0]    alloc_addr;
   logic [`LOOKUP_AW-1:0] ref_ram;
   logic                  magic_ok;
   logic                  slot_rec;
   logic                  has_ram;
   data_id_t              data_id;

   assign download_end = download_q && !ioctl_download &&
                         ioctl_index[5:0] == 6'(`CONFIG_INDEX);

   always_ff @(posedge clk) begin
      if (reset) begin
         download_q <= 1'b0;
         load       <= 1'b0;
      end else begin
         download_q <= ioctl_download;
         load       <= reload | download_end;
         if (download_end) image_size <= ioctl_addr;  // Bytes in the image
      end
   end

   // Header bytes land one cycle after each accepted read
   always_ff @(posedge clk) begin
      if (state == S_HDR_READ && rd_valid) conf[hdr_idx] <= ddr3_dout;
   end

   assign magic_ok     = {conf[0], conf[1], conf[2]} == `MSX_MAGIC;
   assign slot_rec     = config_typ_t'(conf[3][7:4]) == CONFIG_SLOT_INTERNAL;
   assign data_id      = data_id_t'(conf[4]);
   assign fill_units   = {conf[5][2:0], conf[6]};
   assign has_ram      = fill_units != '0;
   assign fill_stream  = data_id != ROM_RAM && data_id != ROM_NONE;
   assign fill_pattern = fill_pattern_t'(conf[11][2:0]);
   assign fill_base    = alloc_addr;
   assign fill_start   = state == S_CHECK && magic_ok && slot_rec && has_ram;

   assign lookup_wr   = fill_start;
   assign lookup_addr = ref_ram;
   assign lookup_data = '{addr: alloc_addr, size: 16'(fill_units), ro: fill_stream};

   assign store_start  = (state == S_CHECK && magic_ok && slot_rec && !has_ram) ||
                         (state == S_FILL && fill_done);
   assign store_slot   = conf[3][3:0];
   assign store_mode   = conf[9];
   assign store_param  = conf[10];
   assign store_mapper = mapper_t'(conf[8]);
   assign store_device = device_t'(conf[7]);
   assign store_ref    = data_id == ROM_NONE ? 4'd0 : ref_ram;

   assign table_clear  = state == S_CLEAR;
   assign fetch_ack    = state == S_FILL && rd_valid;
   assign ddr3_request = state != S_IDLE;
   assign reset_rq     = load || state != S_IDLE;

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= S_IDLE;
         ddr3_rd    <= 1'b0;
         ddr3_addr  <= '0;
         rd_valid   <= 1'b0;
         hdr_idx    <= '0;
         alloc_addr <= '0;
         ref_ram    <= '0;
      end else begin
         rd_valid <= ddr3_rd && ddr3_ready;
         if (ddr3_rd && ddr3_ready) begin
            ddr3_rd   <= 1'b0;
            ddr3_addr <= ddr3_addr + 1'b1;
         end
         case (state)
            S_IDLE: begin
               if (load) begin
                  state      <= S_CLEAR;
                  ddr3_addr  <= '0;
                  alloc_addr <= '0;
                  ref_ram    <= '0;
               end
            end
            S_CLEAR: state <= S_HDR_START;
            S_HDR_START: begin
               hdr_idx <= '0;
               if (ddr3_addr >= `DDR3_AW'(image_size)) begin
                  state <= S_IDLE;  // End of image
               end else begin
                  ddr3_rd <= 1'b1;
                  state   <= S_HDR_READ;
               end
            end
            S_HDR_READ: begin
               if (rd_valid) begin
                  hdr_idx <= hdr_idx + 1'b1;
                  if (hdr_idx == 4'(`CONF_HEADER_BYTES - 1)) state <= S_CHECK;
                  else ddr3_rd <= 1'b1;
               end
            end
            S_CHECK: begin
               if (!magic_ok) begin
                  state <= S_IDLE;
               end else if (!slot_rec) begin
                  state <= S_HDR_START;  // Skipped, no payload follows
               end else if (has_ram) begin
                  alloc_addr <= alloc_addr + (`RAM_AW'(fill_units) << `FILL_UNIT_SHIFT);
                  state      <= S_FILL;
               end else begin
                  state <= S_STORE;
               end
            end
            S_FILL: begin
               if (fetch_req) ddr3_rd <= 1'b1;
               if (fill_done) state <= S_STORE;
            end
            S_STORE: begin
               if (store_done) begin
                  ref_ram <= ref_ram + `LOOKUP_AW'(has_ram);
                  state   <= S_HDR_START;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule
